//--- hdl/bus_pkg.sv
// ====================
// Fill bus definitions
// Beat, tag and response code types of the split-transaction fill bus
// ====================
`default_nettype none

package bus_pkg;

	// Field widths of the fill bus
	localparam int WORD_W = 32;
	localparam int TID_W  = 2;
	localparam int BEAT_W = 2;
	localparam int ERR_W  = 2;

	typedef logic [WORD_W-1:0] word_t;
	// The transaction id is the index of the fill slot that owns the request
	typedef logic [TID_W-1:0]  tid_t;
	typedef logic [BEAT_W-1:0] beat_t;
	typedef logic [ERR_W-1:0]  err_t;

	// Response codes; an interrupt response carries no line data
	localparam err_t ERR_OK  = 2'd0;
	localparam err_t ERR_IRQ = 2'd3;

endpackage

`default_nettype wire

//--- hdl/icache_pkg.sv
// ====================
// Instruction cache geometry
// Fill slot count, way count, line size and address types
// ====================
`default_nettype none

package icache_pkg;

	// Number of fills that may be outstanding at once
	localparam int SLOTS = 4;

	// Set associativity and the width of a way number
	localparam int WAYS     = 4;
	localparam int LOG_WAYS = 2;

	// A line is four 32-bit words, so 16 bytes
	localparam int LINE_WORDS = 4;
	localparam int LINE_W     = LINE_WORDS * 32;

	// Physical address and the byte-in-line bits stripped from it
	localparam int PADR_W = 32;
	localparam int OFFS_W = 4;

	typedef logic [PADR_W-1:0]        padr_t;
	typedef logic [PADR_W-OFFS_W-1:0] line_adr_t;
	typedef logic [LINE_W-1:0]        line_t;
	typedef logic [LOG_WAYS-1:0]      way_t;

endpackage

`default_nettype wire

//--- hdl/fill_if.sv
// ====================
// Fill controller interfaces
// Response and snoop broadcast, and the per-slot control bundle
// ====================
`timescale 1ns/1ps
`default_nettype none

// Registered responses and snoops, broadcast from the generator to all slots
interface fill_resp_if import bus_pkg::*; import icache_pkg::*; ;
	logic      resp_v;
	tid_t      resp_tid;
	beat_t     resp_beat;
	word_t     resp_data;
	logic      snoop_v;
	line_adr_t snoop_adr;

	modport source (
		output resp_v, resp_tid, resp_beat, resp_data, snoop_v, snoop_adr
	);

	modport sink (
		input resp_v, resp_tid, resp_beat, resp_data, snoop_v, snoop_adr
	);
endinterface

// One fill slot, seen from the allocator, the slot itself and the drain side
interface slot_if import icache_pkg::*; ;
	// Allocation from the request generator
	logic      alloc;
	line_adr_t alloc_adr;
	// Slot status
	logic      busy;
	line_adr_t adr;
	logic      done;
	logic      stale;
	line_t     line;
	// Handed back by the ack processor once the line has gone
	logic      slot_release;

	modport gen (output alloc, alloc_adr, input busy, adr);

	modport slot (
		input  alloc, alloc_adr, slot_release,
		output busy, adr, done, stale, line
	);

	modport drain (input done, stale, line, adr, output slot_release);
endinterface

`default_nettype wire

//--- hdl/icache_req_generator.sv
// ====================
// Fill request generator
// Turns fetch misses into tagged bus reads and forwards responses to slots
// ====================
`timescale 1ns/1ps
`default_nettype none

module icache_req_generator import bus_pkg::*; import icache_pkg::*; (
	input  wire logic      clk,
	input  wire logic      arst_n,
	input  wire logic      hit,
	input  wire logic      tlb_v,
	input  wire padr_t     miss_padr,
	input  wire logic      bus_full,
	input  wire logic      resp_ack,
	input  wire err_t      resp_err,
	input  wire tid_t      resp_tid,
	input  wire beat_t     resp_beat,
	input  wire word_t     resp_data,
	input  wire logic      snoop_v,
	input  wire padr_t     snoop_adr,
	output logic           req_v,
	output line_adr_t      req_adr,
	output tid_t           req_tid,
	fill_resp_if.source    resp,
	slot_if.gen            slots [SLOTS]
);

	line_adr_t        miss_line;
	logic [SLOTS-1:0] busy_vec;
	logic [SLOTS-1:0] dup_vec;
	logic             free_found;
	tid_t             free_idx;
	logic             miss_go;

	assign miss_line = miss_padr[PADR_W-1:OFFS_W];

	// ====================
	// Slot status and allocation
	// ====================

	// The interface array can only be indexed by a constant, so gather it here
	for (genvar i = 0; i < SLOTS; i++) begin : g_slot
		assign busy_vec[i] = slots[i].busy;
		// Line already being fetched by some slot
		assign dup_vec[i]  = slots[i].busy && (slots[i].adr == miss_line);
		assign slots[i].alloc     = miss_go && (free_idx == tid_t'(i));
		assign slots[i].alloc_adr = miss_line;
	end

	// Lowest-numbered idle slot wins
	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = SLOTS - 1; i >= 0; i--) begin
			if (!busy_vec[i]) begin
				free_found = 1'b1;
				free_idx   = tid_t'(i);
			end
		end
	end

	// A held miss retries each cycle until every condition is met
	assign miss_go = tlb_v && !hit && !bus_full && free_found && (dup_vec == '0);

	// ====================
	// Bus request
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_v <= 1'b0;
		end else begin
			req_v <= miss_go;
		end
	end

	// The tag is the slot index, so beats find their way back to it
	always_ff @(posedge clk) begin
		if (miss_go) begin
			req_adr <= miss_line;
			req_tid <= free_idx;
		end
	end

	// ====================
	// Response and snoop broadcast
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			resp.resp_v  <= 1'b0;
			resp.snoop_v <= 1'b0;
		end else begin
			// Interrupt responses share the bus but are not line data
			resp.resp_v  <= resp_ack && (resp_err != ERR_IRQ);
			resp.snoop_v <= snoop_v;
		end
	end

	always_ff @(posedge clk) begin
		resp.resp_tid  <= resp_tid;
		resp.resp_beat <= resp_beat;
		resp.resp_data <= resp_data;
		resp.snoop_adr <= snoop_adr[PADR_W-1:OFFS_W];
	end

	// No request may follow a cycle in which the bus reported full,
	// and the slot named by the tag has taken the allocation
	a_no_req_when_full: assert property (@(posedge clk) disable iff (!arst_n)
		req_v |-> !$past(bus_full) && busy_vec[req_tid]);

endmodule

`default_nettype wire

//--- hdl/icache_fill_slot.sv
// ====================
// Fill slot
// Collects the four beats of one outstanding line and tracks snoop hits
// ====================
`timescale 1ns/1ps
`default_nettype none

module icache_fill_slot import bus_pkg::*; import icache_pkg::*; #(
	parameter tid_t SLOT_ID = '0
) (
	input  wire logic   clk,
	input  wire logic   arst_n,
	fill_resp_if.sink   resp,
	slot_if.slot        ctl
);

	typedef enum logic [1:0] {
		SLOT_IDLE,
		SLOT_FILL,
		SLOT_DONE
	} slot_state_t;

	slot_state_t           state;
	logic [LINE_WORDS-1:0] mask_q;
	logic [LINE_WORDS-1:0] mask_nxt;
	logic                  stale_q;
	line_adr_t             adr_q;
	line_t                 line_q;
	logic                  beat_hit;
	logic                  snoop_hit;

	// A beat belongs here when its tag matches this slot
	assign beat_hit  = resp.resp_v && (resp.resp_tid == SLOT_ID);
	assign snoop_hit = resp.snoop_v && (resp.snoop_adr == adr_q);
	assign mask_nxt  = mask_q | (LINE_WORDS'(1) << resp.resp_beat);

	// ====================
	// Slot FSM
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= SLOT_IDLE;
			mask_q  <= '0;
			stale_q <= 1'b0;
		end else begin
			case (state)
				SLOT_IDLE: begin
					if (ctl.alloc) begin
						state   <= SLOT_FILL;
						mask_q  <= '0;
						stale_q <= 1'b0;
					end
				end
				SLOT_FILL: begin
					// Once invalidated, the line is still collected but never written
					if (snoop_hit)
						stale_q <= 1'b1;
					if (beat_hit) begin
						mask_q <= mask_nxt;
						if (&mask_nxt)
							state <= SLOT_DONE;
					end
				end
				SLOT_DONE: begin
					if (ctl.slot_release)
						state <= SLOT_IDLE;
				end
				default: state <= SLOT_IDLE;
			endcase
		end
	end

	// Line address and data words
	always_ff @(posedge clk) begin
		if (state == SLOT_IDLE && ctl.alloc)
			adr_q <= ctl.alloc_adr;
		// Beats can come in any order, the beat index picks the word
		if (state == SLOT_FILL && beat_hit)
			line_q[resp.resp_beat*WORD_W +: WORD_W] <= resp.resp_data;
	end

	assign ctl.busy  = (state != SLOT_IDLE);
	assign ctl.done  = (state == SLOT_DONE);
	assign ctl.stale = stale_q;
	assign ctl.adr   = adr_q;
	assign ctl.line  = line_q;

	// Beats for this tag only arrive after a request was issued from this slot
	a_no_beat_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		beat_hit |-> (state != SLOT_IDLE));

endmodule

`default_nettype wire

//--- hdl/icache_ack_processor.sv
// ====================
// Ack processor
// Drains finished slots into the cache with a round-robin victim way
// ====================
`timescale 1ns/1ps
`default_nettype none

module icache_ack_processor import icache_pkg::*; (
	input  wire logic   clk,
	input  wire logic   arst_n,
	output logic        wr_ic,
	output way_t        way,
	output line_adr_t   line_adr,
	output line_t       line_o,
	slot_if.drain       slots [SLOTS]
);

	logic [SLOTS-1:0] done_vec;
	logic [SLOTS-1:0] stale_vec;
	logic [SLOTS-1:0] release_q;
	logic [SLOTS-1:0] cand_vec;
	line_t            line_arr [SLOTS];
	line_adr_t        adr_arr [SLOTS];
	logic             pick_v;
	int unsigned      pick_idx;
	way_t             way_q;

	// Flatten the slot interfaces into plain vectors
	for (genvar i = 0; i < SLOTS; i++) begin : g_slot
		assign done_vec[i]  = slots[i].done;
		assign stale_vec[i] = slots[i].stale;
		assign line_arr[i]  = slots[i].line;
		assign adr_arr[i]   = slots[i].adr;
		assign slots[i].slot_release = release_q[i];
	end

	// A slot being released this cycle still shows done, so skip it
	assign cand_vec = done_vec & ~release_q;

	// Lowest-numbered finished slot goes first
	always_comb begin
		pick_v   = 1'b0;
		pick_idx = 0;
		for (int i = SLOTS - 1; i >= 0; i--) begin
			if (cand_vec[i]) begin
				pick_v   = 1'b1;
				pick_idx = i;
			end
		end
	end

	// ====================
	// Cache write and release
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			release_q <= '0;
			wr_ic     <= 1'b0;
			way_q     <= '0;
		end else begin
			release_q <= pick_v ? (SLOTS'(1) << pick_idx) : '0;
			// Stale lines are dropped, only the slot is handed back
			wr_ic     <= pick_v && !stale_vec[pick_idx];
			// Victim way steps once per line actually written
			if (wr_ic)
				way_q <= (way_q == way_t'(WAYS - 1)) ? '0 : way_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pick_v) begin
			line_o   <= line_arr[pick_idx];
			line_adr <= adr_arr[pick_idx];
		end
	end

	assign way = way_q;

	// At most one slot is handed back, and it still holds a finished line
	a_release_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(release_q) && ((release_q & ~done_vec) == '0));

endmodule

`default_nettype wire

//--- hdl/icache_fill_top.sv
// ====================
// Instruction cache fill controller
// Request generator, fill slots and ack processor joined by interfaces
// ====================
`timescale 1ns/1ps
`default_nettype none

module icache_fill_top import bus_pkg::*; import icache_pkg::*; (
	input  wire logic      clk,
	input  wire logic      arst_n,
	// Fetch stage
	input  wire logic      hit,
	input  wire logic      tlb_v,
	input  wire padr_t     miss_padr,
	// Bus request
	input  wire logic      bus_full,
	output logic           req_v,
	output line_adr_t      req_adr,
	output tid_t           req_tid,
	// Bus response
	input  wire logic      resp_ack,
	input  wire err_t      resp_err,
	input  wire tid_t      resp_tid,
	input  wire beat_t     resp_beat,
	input  wire word_t     resp_data,
	// Snoop
	input  wire logic      snoop_v,
	input  wire padr_t     snoop_adr,
	// Cache write
	output logic           wr_ic,
	output way_t           way,
	output line_adr_t      line_adr,
	output line_t          line_o
);

	fill_resp_if resp_bus ();
	slot_if      slot_bus [SLOTS] ();

	// Misses in, tagged requests out, responses fanned out to the slots
	icache_req_generator u_req_gen (
		.clk       (clk),
		.arst_n    (arst_n),
		.hit       (hit),
		.tlb_v     (tlb_v),
		.miss_padr (miss_padr),
		.bus_full  (bus_full),
		.resp_ack  (resp_ack),
		.resp_err  (resp_err),
		.resp_tid  (resp_tid),
		.resp_beat (resp_beat),
		.resp_data (resp_data),
		.snoop_v   (snoop_v),
		.snoop_adr (snoop_adr),
		.req_v     (req_v),
		.req_adr   (req_adr),
		.req_tid   (req_tid),
		.resp      (resp_bus),
		.slots     (slot_bus)
	);

	// One slot per outstanding fill, its index doubles as the bus tag
	for (genvar i = 0; i < SLOTS; i++) begin : g_slot
		icache_fill_slot #(
			.SLOT_ID (tid_t'(i))
		) u_slot (
			.clk    (clk),
			.arst_n (arst_n),
			.resp   (resp_bus),
			.ctl    (slot_bus[i])
		);
	end

	icache_ack_processor u_ack_proc (
		.clk      (clk),
		.arst_n   (arst_n),
		.wr_ic    (wr_ic),
		.way      (way),
		.line_adr (line_adr),
		.line_o   (line_o),
		.slots    (slot_bus)
	);

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
// ====================
// Testbench clock and reset
// 8 ns clock, reset held low for three cycles
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD = 4;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset is let go on a falling edge, clear of the sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/tb_checker.sv
// ====================
// Fill controller checker
// Tracks requests, beats and snoops per tag and checks every cache write
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_checker import bus_pkg::*; import icache_pkg::*; (
	input  wire logic      clk,
	input  wire logic      arst_n,
	input  wire logic      bus_full,
	input  wire logic      req_v,
	input  wire line_adr_t req_adr,
	input  wire tid_t      req_tid,
	input  wire logic      resp_ack,
	input  wire err_t      resp_err,
	input  wire tid_t      resp_tid,
	input  wire beat_t     resp_beat,
	input  wire logic      snoop_v,
	input  wire padr_t     snoop_adr,
	input  wire logic      wr_ic,
	input  wire way_t      way,
	input  wire line_adr_t line_adr,
	input  wire line_t     line_o,
	output int             mismatches,
	output int             failures,
	output int             writes
);

	// Model of the outstanding fills, one entry per tag
	logic [SLOTS-1:0]      ent_v;
	logic [SLOTS-1:0]      ent_stale;
	logic [SLOTS-1:0]      ent_full;
	line_adr_t             ent_adr [SLOTS];
	logic [LINE_WORDS-1:0] ent_mask [SLOTS];
	// Inputs seen at the previous edge
	logic                  full_q;
	logic                  snoop_q;
	line_adr_t             snoop_line_q;
	way_t                  exp_way;
	int                    post_rst;
	int                    mism_cnt = 0;
	int                    fail_cnt = 0;
	int                    write_cnt = 0;

	assign mismatches = mism_cnt;
	assign failures   = fail_cnt;
	assign writes     = write_cnt;

	task automatic flag_mismatch(input string msg);
		mism_cnt++;
		$display("MISMATCH at %0t ns: %s", $time, msg);
	endtask

	task automatic flag_failure(input string msg);
		fail_cnt++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	// Word b of a line is the line address times four plus b
	function automatic line_t expect_line(input line_adr_t adr);
		line_t l;
		l = '0;
		for (int b = 0; b < LINE_WORDS; b++)
			l[b*32 +: 32] = word_t'({2'b00, adr, 2'b00}) + word_t'(b);
		return l;
	endfunction

	// ====================
	// Request, snoop, beat and write rules
	// ====================

	// A request seen here was made at the previous edge
	task automatic take_request();
		if (full_q)
			flag_mismatch($sformatf("request for line %h while bus was full", req_adr));
		for (int i = 0; i < SLOTS; i++) begin
			if (ent_v[i] && ent_adr[i] == req_adr)
				flag_mismatch($sformatf("request repeats outstanding line %h", req_adr));
		end
		if (ent_v[req_tid])
			flag_mismatch($sformatf("tag %0d reused while its fill is open", req_tid));
		ent_v[req_tid]     = 1'b1;
		ent_full[req_tid]  = 1'b0;
		ent_mask[req_tid]  = '0;
		ent_adr[req_tid]   = req_adr;
		// A snoop at the request edge already hits the new fill
		ent_stale[req_tid] = snoop_q && (snoop_line_q == req_adr);
	endtask

	task automatic take_beat();
		if (!ent_v[resp_tid] || ent_full[resp_tid] || ent_mask[resp_tid][resp_beat]) begin
			flag_failure($sformatf("memory model sent beat for tag %0d with no open request",
				resp_tid));
		end else begin
			ent_mask[resp_tid][resp_beat] = 1'b1;
			if (&ent_mask[resp_tid]) begin
				// A snooped fill is dropped by the DUT without a write
				if (ent_stale[resp_tid])
					ent_v[resp_tid] = 1'b0;
				else
					ent_full[resp_tid] = 1'b1;
			end
		end
	endtask

	task automatic check_write();
		int hit_idx;
		hit_idx = -1;
		for (int i = 0; i < SLOTS; i++) begin
			if (ent_v[i] && ent_full[i] && ent_adr[i] == line_adr)
				hit_idx = i;
		end
		if (hit_idx < 0) begin
			flag_mismatch($sformatf("write of line %h with no clean finished fill", line_adr));
		end else begin
			if (line_o !== expect_line(line_adr))
				flag_mismatch($sformatf("line %h data %h, expected %h", line_adr, line_o,
					expect_line(line_adr)));
			ent_v[hit_idx] = 1'b0;
		end
		if (way !== exp_way)
			flag_mismatch($sformatf("way %0d, expected %0d", way, exp_way));
		exp_way = way_t'((int'(exp_way) + 1) % WAYS);
		write_cnt++;
	endtask

	always @(posedge clk) begin
		if (!arst_n) begin
			if (req_v || wr_ic)
				flag_mismatch("req_v or wr_ic high during reset");
			ent_v    = '0;
			exp_way  = '0;
			post_rst = 0;
		end else begin
			if (post_rst < 1 && (req_v || wr_ic))
				flag_mismatch("req_v or wr_ic high right after reset");
			if (post_rst < 1)
				post_rst++;
			if (req_v)
				take_request();
			// A snoop counts up to and including the edge of the last beat
			if (snoop_v) begin
				for (int i = 0; i < SLOTS; i++) begin
					if (ent_v[i] && !ent_full[i] && ent_adr[i] == snoop_adr[PADR_W-1:OFFS_W])
						ent_stale[i] = 1'b1;
				end
			end
			// Interrupt responses carry no line data
			if (resp_ack && resp_err != ERR_IRQ)
				take_beat();
			if (wr_ic)
				check_write();
		end
		full_q       = bus_full;
		snoop_q      = snoop_v;
		snoop_line_q = snoop_adr[PADR_W-1:OFFS_W];
	end

endmodule

`default_nettype wire

//--- tb/tb_icache_fill.sv
// ====================
// Fill controller testbench
// Random fetch misses, an out-of-order memory model, snoops and back-pressure
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_icache_fill import bus_pkg::*; import icache_pkg::*; ;

	localparam int LINES_TO_WRITE  = 300;
	localparam int CYCLES_PER_LINE = 130;
	localparam int MAX_CYCLES      = LINES_TO_WRITE * CYCLES_PER_LINE + 1000;
	// Small address pool so that the same lines come back often
	localparam int POOL  = 8;
	localparam int NPEND = 4;

	logic      clk;
	logic      arst_n;
	logic      hit;
	logic      tlb_v;
	padr_t     miss_padr;
	logic      bus_full;
	logic      req_v;
	line_adr_t req_adr;
	tid_t      req_tid;
	logic      resp_ack;
	err_t      resp_err;
	tid_t      resp_tid;
	beat_t     resp_beat;
	word_t     resp_data;
	logic      snoop_v;
	padr_t     snoop_adr;
	logic      wr_ic;
	way_t      way;
	line_adr_t line_adr;
	line_t     line_o;
	int        mismatches;
	int        failures;
	int        writes;

	// Fetch stage, lines that still miss
	logic [NPEND-1:0]      pend_v;
	line_adr_t             pend_adr [NPEND];
	int                    pend_rot;
	int                    hit_cnt;
	// Memory, one open read per tag and its beats not yet sent
	logic [SLOTS-1:0]      mem_v;
	line_adr_t             mem_adr [SLOTS];
	logic [LINE_WORDS-1:0] mem_left [SLOTS];
	int                    cycles;
	logic                  timed_out;

	tb_clkgen u_clkgen (.clk(clk), .arst_n(arst_n));

	icache_fill_top dut (.*);

	tb_checker u_checker (.*);

	function automatic line_adr_t pool_line(input int idx);
		return line_adr_t'(32'h02468A00 + 32'(idx) * 32'h131);
	endfunction

	task automatic init_inputs();
		// The fetch stage already misses while reset is held
		hit       = 1'b0;
		tlb_v     = 1'b1;
		miss_padr = {pool_line(0), 4'h0};
		bus_full  = 1'b0;
		resp_ack  = 1'b0;
		resp_err  = ERR_OK;
		resp_tid  = '0;
		resp_beat = '0;
		resp_data = '0;
		snoop_v   = 1'b0;
		snoop_adr = '0;
	endtask

	// A miss stays pending until its line is written, then a short run of hits
	task automatic drive_fetch();
		int   pick;
		int   idx;
		logic filled;
		if (wr_ic) begin
			for (int i = 0; i < NPEND; i++) begin
				if (pend_v[i] && pend_adr[i] == line_adr)
					pend_v[i] = 1'b0;
			end
			hit_cnt = 1 + int'($urandom % 3);
		end
		filled = 1'b0;
		for (int i = 0; i < NPEND; i++) begin
			if (!pend_v[i] && !filled) begin
				pend_v[i]   = 1'b1;
				pend_adr[i] = pool_line(int'($urandom % POOL));
				filled      = 1'b1;
			end
		end
		if (hit_cnt > 0) begin
			tlb_v = 1'b1;
			hit   = 1'b1;
			hit_cnt--;
		end else begin
			// Pending misses take turns on the single miss port
			pick = -1;
			for (int k = 0; k < NPEND; k++) begin
				idx = (pend_rot + k) % NPEND;
				if (pend_v[idx] && pick < 0)
					pick = idx;
			end
			pend_rot  = (pend_rot + 1) % NPEND;
			hit       = 1'b0;
			tlb_v     = (pick >= 0) && ($urandom % 10 != 0);
			if (pick >= 0)
				miss_padr = {pend_adr[pick], 4'($urandom % 16)};
		end
	endtask

	// Beats of all open reads are mixed in random order with gaps
	task automatic drive_memory();
		int roll;
		int start;
		int t;
		int b;
		if (req_v) begin
			mem_v[req_tid]    = 1'b1;
			mem_adr[req_tid]  = req_adr;
			mem_left[req_tid] = '1;
		end
		resp_ack = 1'b0;
		resp_err = ERR_OK;
		roll     = int'($urandom % 100);
		start    = int'($urandom % SLOTS);
		t        = -1;
		for (int k = 0; k < SLOTS; k++) begin
			if (mem_v[(start + k) % SLOTS] && t < 0)
				t = (start + k) % SLOTS;
		end
		if (t >= 0 && roll < 8) begin
			// Interrupt response on a live tag, the data is junk
			resp_ack  = 1'b1;
			resp_err  = ERR_IRQ;
			resp_tid  = tid_t'(t);
			resp_beat = beat_t'($urandom % 4);
			resp_data = $urandom;
		end else if (t >= 0 && roll < 60) begin
			start = int'($urandom % LINE_WORDS);
			b     = -1;
			for (int k = 0; k < LINE_WORDS; k++) begin
				if (mem_left[t][(start + k) % LINE_WORDS] && b < 0)
					b = (start + k) % LINE_WORDS;
			end
			resp_ack  = 1'b1;
			resp_tid  = tid_t'(t);
			resp_beat = beat_t'(b);
			resp_data = word_t'({2'b00, mem_adr[t], 2'b00}) + word_t'(b);
			mem_left[t][b] = 1'b0;
			if (mem_left[t] == '0)
				mem_v[t] = 1'b0;
		end
		bus_full = ($urandom % 100) < 15;
		// Half the snoops aim at a line that is being filled
		snoop_v  = ($urandom % 100) < 4;
		if (t >= 0 && $urandom % 2 == 0)
			snoop_adr = {mem_adr[t], 4'h0};
		else
			snoop_adr = {pool_line(int'($urandom % POOL)), 4'($urandom % 16)};
	endtask

	initial begin
		init_inputs();
		void'($urandom(46738));
		pend_v    = '0;
		mem_v     = '0;
		pend_rot  = 0;
		hit_cnt   = 0;
		cycles    = 0;
		timed_out = 1'b0;
		@(posedge arst_n);
		while (writes < LINES_TO_WRITE && !timed_out) begin
			@(negedge clk);
			cycles++;
			if (cycles >= MAX_CYCLES) begin
				timed_out = 1'b1;
				$display("Timeout after %0d cycles, only %0d of %0d lines written",
					cycles, writes, LINES_TO_WRITE);
			end else begin
				drive_fetch();
				drive_memory();
			end
		end
		$display("Errors: %0d mismatches, %0d other failures, %0d lines written",
			mismatches, failures + int'(timed_out), writes);
		if (mismatches == 0 && failures == 0 && !timed_out)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- icache_fill.f
hdl/bus_pkg.sv
hdl/icache_pkg.sv
hdl/fill_if.sv
hdl/icache_req_generator.sv
hdl/icache_fill_slot.sv
hdl/icache_ack_processor.sv
hdl/icache_fill_top.sv
tb/tb_clkgen.sv
tb/tb_checker.sv
tb/tb_icache_fill.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction cache fill controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module tb_icache_fill -f icache_fill.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_icache_fill)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
